// ==== source/isa_pkg.sv ====
/* instruction word layout and ALU function codes of the RISC5 kind core.
   function codes C to F have no name and execute as zero. */

package isa_pkg;

  // --------------------------------------------------------------------------
  // instruction format, bits [31:30]
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    fmt_reg    = 2'd0,  // register/register
    fmt_imm    = 2'd1,  // register/immediate
    fmt_mem    = 2'd2,  // load/store, halts the core
    fmt_branch = 2'd3   // branch, halts the core
  } fmt_t;

  typedef enum logic [3:0] {
    fnc_mov = 4'h0,
    fnc_lsl = 4'h1,
    fnc_asr = 4'h2,
    fnc_ror = 4'h3,
    fnc_and = 4'h4,
    fnc_ann = 4'h5,     // and not
    fnc_ior = 4'h6,
    fnc_xor = 4'h7,
    fnc_add = 4'h8,
    fnc_sub = 4'h9,
    fnc_mul = 4'hA      // low product word, multicycle
  } alu_fnc_t;

  // --------------------------------------------------------------------------
  // the two views of one instruction word
  // --------------------------------------------------------------------------
  typedef struct packed {
    fmt_t        pq;
    logic        u;
    logic        v;
    logic [3:0]  a;       // destination
    logic [3:0]  b;       // first source
    logic [3:0]  op;
    logic [11:0] unused;
    logic [3:0]  c;       // second source
  } instr_reg_t;

  typedef struct packed {
    fmt_t        pq;
    logic        u;
    logic        v;       // fill bit for the upper half
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  op;
    logic [15:0] imm;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_t;

endpackage

// ==== source/bus_pkg.sv ====
/* fetch request and write-back trace of the core.
   the fetch bus is read only, word addressed by a 24-bit byte address. */

package bus_pkg;

  // stb held with stable addr until ack
  typedef struct packed {
    logic        stb;
    logic [23:0] addr;
  } fetch_req_t;

  // one register write, valid for a single cycle
  typedef struct packed {
    logic        valid;
    logic [3:0]  idx;
    logic [31:0] data;
  } wb_trace_t;

endpackage

// ==== source/cpu_regfile.sv ====
/* 16 x 32 register file, both reads registered, write goes to a2.
   no reset, contents are undefined until written. */

`timescale 1ns/100ps

module cpu_regfile (
  input  logic        clk,
  input  logic [3:0]  a1,
  input  logic [3:0]  a2,
  output logic [31:0] do1,
  output logic [31:0] do2,
  input  logic        we,
  input  logic [31:0] di
);

  logic [31:0] regs [16];

  always_ff @(posedge clk) begin
    do1 <= regs[a1];
    do2 <= regs[a2];                // old value on a write to the same index
    if (we) begin
      regs[a2] <= di;
    end
  end

endmodule

// ==== source/cpu_mul.sv ====
/* sequential shift-add multiplier, low 32 product bits only.
   start must stay high and operands stable until busy falls; prod is
   valid in the first cycle with start high and busy low. */

`timescale 1ns/100ps

module cpu_mul (
  input  logic        clk,
  input  logic        start,
  input  logic [31:0] op1,
  input  logic [31:0] op2,
  output logic        busy,
  output logic [31:0] prod
);

  logic [5:0]  cnt;                 // steps done, 0..32
  logic [31:0] mcand;               // shifted multiplicand
  logic [31:0] mplier;              // remaining multiplier bits
  logic [31:0] acc;
  logic        first;
  logic [31:0] mc;
  logic [31:0] mp;
  logic [31:0] acc_in;

  // first step takes the operands straight from the ports
  always_comb begin
    first  = (cnt == 6'd0);
    mc     = first ? op1 : mcand;
    mp     = first ? op2 : mplier;
    acc_in = first ? 32'h0 : acc;
  end

  assign busy = start & (cnt != 6'd32);

  always_ff @(posedge clk) begin
    if (!start) begin
      cnt <= 6'd0;                  // idle between runs
    end else if (busy) begin
      cnt    <= cnt + 6'd1;
      acc    <= acc_in + (mp[0] ? mc : 32'h0);
      mcand  <= mc << 1;
      mplier <= mp >> 1;
    end
  end

  assign prod = acc;

endmodule

// ==== source/cpu_alu.sv ====
/* ALU: move, shifts, logic, add/sub and the multiplier.
   shift counts use op2[4:0]; codes C to F give zero.
   stall is high while a multiply runs. */

`timescale 1ns/100ps

module cpu_alu (
  input  logic               clk,
  input  logic               run,
  output logic               stall,
  input  logic [31:0]        op1,
  input  logic [31:0]        op2,
  input  isa_pkg::alu_fnc_t  fnc,
  output logic [31:0]        res
);

  logic [4:0]  shcnt;
  logic [31:0] lsl_res;
  logic [31:0] asr_res;
  logic [63:0] ror_wide;
  logic [31:0] mul_res;
  logic        mul_busy;

  assign shcnt    = op2[4:0];
  assign lsl_res  = op1 << shcnt;
  assign asr_res  = $signed(op1) >>> shcnt;   // fills from bit 31
  assign ror_wide = {op1, op1} >> shcnt;

  cpu_mul u_mul (
    .clk   (clk),
    .start (run && (fnc == isa_pkg::fnc_mul)),
    .op1   (op1),
    .op2   (op2),
    .busy  (mul_busy),
    .prod  (mul_res)
  );

  assign stall = mul_busy;

  always_comb begin
    case (fnc)
      isa_pkg::fnc_mov: res = op2;
      isa_pkg::fnc_lsl: res = lsl_res;
      isa_pkg::fnc_asr: res = asr_res;
      isa_pkg::fnc_ror: res = ror_wide[31:0];
      isa_pkg::fnc_and: res = op1 & op2;
      isa_pkg::fnc_ann: res = op1 & ~op2;
      isa_pkg::fnc_ior: res = op1 | op2;
      isa_pkg::fnc_xor: res = op1 ^ op2;
      isa_pkg::fnc_add: res = op1 + op2;  // wraps
      isa_pkg::fnc_sub: res = op1 - op2;
      isa_pkg::fnc_mul: res = mul_res;
      default:          res = 32'h0;     // C..F unsupported
    endcase
  end

endmodule

// ==== source/cpu_ctrl.sv ====
/* fetch/decode/execute/write-back controller.
   memory and branch formats end in a halt state left only by reset.
   outputs decode the state, so they are quiet during reset. */

`timescale 1ns/100ps

module cpu_ctrl (
  input  logic          clk,
  input  logic          rst,
  input  isa_pkg::fmt_t pq,
  input  logic          bus_ack,
  input  logic          stall,
  output logic          stb,
  output logic          pc_we,
  output logic          pc_sel,     // 0 reset vector, 1 alu result
  output logic          ir_we,
  output logic          a2_sel,     // 0 register c, 1 register a
  output logic          reg_we,
  output logic          alu_run,
  output logic          src1_sel,   // 0 pc, 1 register b
  output logic [1:0]    src2_sel,   // 0 constant 4, 1 register c, 2 immediate
  output logic          alu_add,
  output logic          halted
);

  typedef enum logic [2:0] {
    st_reset,
    st_fetch,
    st_decode,
    st_exec,
    st_wb,
    st_halt
  } state_t;

  state_t state;
  state_t next_state;

  // --------------------------------------------------------------------------
  // state register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_reset;
    end else begin
      state <= next_state;
    end
  end

  // --------------------------------------------------------------------------
  // next state and outputs
  // --------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    stb        = 1'b0;
    pc_we      = 1'b0;
    pc_sel     = 1'b0;
    ir_we      = 1'b0;
    a2_sel     = 1'b0;
    reg_we     = 1'b0;
    alu_run    = 1'b0;
    src1_sel   = 1'b0;
    src2_sel   = 2'd0;
    alu_add    = 1'b0;
    halted     = 1'b0;

    case (state)
      st_reset: begin
        pc_we      = 1'b1;          // load reset vector
        next_state = st_fetch;
      end

      st_fetch: begin
        stb      = 1'b1;
        pc_sel   = 1'b1;
        src1_sel = 1'b0;            // pc + 4
        src2_sel = 2'd0;
        alu_add  = 1'b1;
        pc_we    = bus_ack;
        ir_we    = bus_ack;
        if (bus_ack) begin
          next_state = st_decode;
        end
      end

      // register reads of b and c happen on this edge
      st_decode: begin
        if (pq == isa_pkg::fmt_reg || pq == isa_pkg::fmt_imm) begin
          next_state = st_exec;
        end else begin
          next_state = st_halt;
        end
      end

      st_exec: begin
        alu_run  = 1'b1;            // level, also for immediates
        src1_sel = 1'b1;
        src2_sel = (pq == isa_pkg::fmt_imm) ? 2'd2 : 2'd1;
        if (!stall) begin
          next_state = st_wb;
        end
      end

      st_wb: begin
        a2_sel     = 1'b1;
        reg_we     = 1'b1;
        next_state = st_fetch;
      end

      st_halt: begin
        halted = 1'b1;
      end

      default: begin
        next_state = st_reset;
      end
    endcase
  end

endmodule

// ==== source/cpu_core.sv ====
/* multicycle RISC5-style core, register and immediate formats only.
   fetch uses stb/ack; reset_pc is the first fetch address.
   register file has no reset, programs write before they read. */

`timescale 1ns/100ps

module cpu_core #(
  parameter logic [23:0] reset_pc = 24'hFFE000
) (
  input  logic                clk,
  input  logic                rst,
  output bus_pkg::fetch_req_t fetch_req,
  input  logic [31:0]         bus_din,
  input  logic                bus_ack,
  output bus_pkg::wb_trace_t  wb_trace,
  output logic                halted
);

  logic [23:0]          pc;
  isa_pkg::instr_t      ir;
  logic [31:0]          alu_out;    // result, one cycle late
  logic [31:0]          alu_res;
  logic [31:0]          op1;
  logic [31:0]          op2;
  logic [31:0]          reg_do1;
  logic [31:0]          reg_do2;
  logic [3:0]           reg_a2;
  isa_pkg::alu_fnc_t    alu_fnc;

  logic       pc_we;
  logic       pc_sel;
  logic       ir_we;
  logic       a2_sel;
  logic       reg_we;
  logic       alu_run;
  logic       alu_stall;
  logic       src1_sel;
  logic [1:0] src2_sel;
  logic       alu_add;
  logic       stb;

  // --------------------------------------------------------------------------
  // pc, ir and delayed alu result
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (pc_we) begin
      pc <= pc_sel ? alu_res[23:0] : reset_pc;
    end
    if (ir_we) begin
      ir <= bus_din;
    end
    alu_out <= alu_res;
  end

  assign fetch_req = '{stb: stb, addr: pc};

  // --------------------------------------------------------------------------
  // operands
  // --------------------------------------------------------------------------
  assign reg_a2 = a2_sel ? ir.r.a : ir.r.c;
  assign op1    = src1_sel ? reg_do1 : {8'h00, pc};

  always_comb begin
    case (src2_sel)
      2'd1:    op2 = reg_do2;
      2'd2:    op2 = {{16{ir.i.v}}, ir.i.imm};  // v fills the upper half
      default: op2 = 32'h0000_0004;
    endcase
  end

  assign alu_fnc = alu_add ? isa_pkg::fnc_add : isa_pkg::alu_fnc_t'(ir.r.op);

  // --------------------------------------------------------------------------
  // instances
  // --------------------------------------------------------------------------
  cpu_ctrl u_ctrl (
    .clk(clk), .rst(rst), .pq(ir.r.pq), .bus_ack(bus_ack), .stall(alu_stall),
    .stb(stb), .pc_we(pc_we), .pc_sel(pc_sel), .ir_we(ir_we), .a2_sel(a2_sel),
    .reg_we(reg_we), .alu_run(alu_run), .src1_sel(src1_sel),
    .src2_sel(src2_sel), .alu_add(alu_add), .halted(halted)
  );

  cpu_regfile u_regfile (
    .clk(clk), .a1(ir.r.b), .a2(reg_a2), .do1(reg_do1), .do2(reg_do2),
    .we(reg_we), .di(alu_out)
  );

  cpu_alu u_alu (
    .clk(clk), .run(alu_run), .stall(alu_stall), .op1(op1), .op2(op2),
    .fnc(alu_fnc), .res(alu_res)
  );

  // trace mirrors the register write
  assign wb_trace = '{valid: reg_we, idx: ir.r.a, data: alu_out};

endmodule

// ==== tb/cpu_checker.sv ====
/* compares the write-back trace of cpu_core with the expected list,
   one entry per write in program order; watches halted and stb after a halt. */

`timescale 1ns/100ps

module cpu_checker #(
  parameter int max_words = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  bus_pkg::wb_trace_t  wb_trace,
  input  bus_pkg::fetch_req_t fetch_req,
  input  logic                halted,
  input  logic [3:0]          exp_idx [max_words],
  input  logic [31:0]         exp_data [max_words],
  input  int                  exp_count,
  input  logic                halt_exp,
  input  logic                end_check,
  output logic                end_done,
  output int                  value_errors,
  output int                  seq_errors
);

  int   got;                        // write-backs seen so far
  logic halt_seen;
  logic stb_flagged;
  logic drop_flagged;

  // outputs are sampled mid-cycle, away from the rising edge
  always @(negedge clk) begin
    if (rst) begin
      got          = 0;
      halt_seen    = 1'b0;
      stb_flagged  = 1'b0;
      drop_flagged = 1'b0;
      end_done     = 1'b0;
      value_errors = 0;
      seq_errors   = 0;
    end else begin
      if (wb_trace.valid) begin
        if (halt_seen) begin
          $display("write-back to r%0d after the halt", wb_trace.idx);
          seq_errors++;
        end else if (got >= exp_count) begin
          $display("extra write-back to r%0d with %h", wb_trace.idx, wb_trace.data);
          seq_errors++;
        end else begin
          if (wb_trace.idx !== exp_idx[got]) begin
            $display("Error: wb_trace.idx is %h, expected %h (write-back %0d)",
                     wb_trace.idx, exp_idx[got], got);
            value_errors++;
          end
          if (wb_trace.data !== exp_data[got]) begin
            $display("Error: wb_trace.data is %h, expected %h (write-back %0d)",
                     wb_trace.data, exp_data[got], got);
            value_errors++;
          end
        end
        got++;
      end

      if (halted && !halt_seen) begin
        if (!halt_exp) begin
          $display("the core halted although no halt is expected");
          seq_errors++;
        end
        halt_seen = 1'b1;
      end
      if (halt_seen && !halted && !drop_flagged) begin
        $display("halted fell before a reset");
        seq_errors++;
        drop_flagged = 1'b1;
      end
      if (halt_seen && fetch_req.stb && !stb_flagged) begin
        $display("fetch strobe high after the halt");
        seq_errors++;
        stb_flagged = 1'b1;
      end

      // end of run, anything still outstanding
      if (end_check && !end_done) begin
        if (got < exp_count) begin
          $display("%0d expected write-backs are missing", exp_count - got);
          seq_errors++;
        end
        if (halt_exp && !halt_seen) begin
          $display("the core did not halt");
          seq_errors++;
        end
        end_done = 1'b1;
      end
    end
  end

endmodule

// ==== tb/tb_cpu.sv ====
/* testbench for cpu_core with reset_pc 0 and at most 64 program words.
   program and expected write-backs come from tb/cpu_testdata.txt,
   so the run starts in the project root. */

`timescale 1ns/100ps

module tb_cpu;

  localparam int max_words = 64;

  logic                clk     = 1'b0;
  logic                rst;
  bus_pkg::fetch_req_t fetch_req;
  logic [31:0]         bus_din = 32'h0;
  logic                bus_ack = 1'b0;
  bus_pkg::wb_trace_t  wb_trace;
  logic                halted;

  logic [31:0] mem [max_words];
  logic [3:0]  exp_idx [max_words];
  logic [31:0] exp_data [max_words];
  int          prog_len     = 0;
  int          exp_count    = 0;
  logic        halt_exp     = 1'b0;
  logic        end_check;
  logic        end_done;
  int          value_errors;
  int          seq_errors;
  int          load_errors  = 0;
  int          fetch_errors = 0;
  int          cycle_cnt    = 0;
  int          cycle_limit  = 0;
  int          wait_left    = -1;   // ack delay left, -1 when idle
  int          widx;
  logic [31:0] rng          = 32'hf874_a24d;

  always #2 clk = ~clk;

  cpu_core #(.reset_pc(24'h000000)) uut (
    .clk(clk), .rst(rst), .fetch_req(fetch_req), .bus_din(bus_din),
    .bus_ack(bus_ack), .wb_trace(wb_trace), .halted(halted)
  );

  cpu_checker #(.max_words(max_words)) chk (
    .clk(clk), .rst(rst), .wb_trace(wb_trace), .fetch_req(fetch_req),
    .halted(halted), .exp_idx(exp_idx), .exp_data(exp_data),
    .exp_count(exp_count), .halt_exp(halt_exp), .end_check(end_check),
    .end_done(end_done), .value_errors(value_errors), .seq_errors(seq_errors)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // branch-format word holding the address, halts the core
  function automatic logic [31:0] fill_word(input logic [23:0] addr);
    return {8'hC0, addr};
  endfunction

  task automatic load_testdata();
    int          fd;
    int          code;
    int          ch;
    logic [7:0]  tag;
    logic [31:0] word;
    logic [3:0]  idx;
    fd = $fopen("tb/cpu_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/cpu_testdata.txt");
      load_errors++;
      return;
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "I" && prog_len < max_words) begin
        code = $fscanf(fd, "%h", word);
        if (code != 1) begin
          $display("program word missing after an I entry in the test data");
          load_errors++;
        end
        mem[prog_len] = word;
        prog_len++;
      end else if (tag == "W" && exp_count < max_words) begin
        code = $fscanf(fd, "%h %h", idx, word);
        if (code != 2) begin
          $display("register or value missing after a W entry in the test data");
          load_errors++;
        end
        exp_idx[exp_count]  = idx;
        exp_data[exp_count] = word;
        exp_count++;
      end else if (tag == "H") begin
        halt_exp = 1'b1;
      end else if (tag == "#") begin
        ch = $fgetc(fd);                // skip the comment line
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        $display("unexpected entry in the test data");
        load_errors++;
      end
    end
    $fclose(fd);
  endtask

  task automatic report_counts();
    $display("errors: %0d value, %0d sequence, %0d test setup", value_errors,
             seq_errors, load_errors + fetch_errors);
  endtask

  // --------------------------------------------------------------------------
  // instruction memory, ack after 0 to 3 cycles
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    bus_ack <= 1'b0;
    if (rst || !fetch_req.stb) begin
      wait_left = -1;
    end else begin
      if (wait_left < 0) begin
        rng       = lcg_step(rng);
        wait_left = int'(rng[17:16]);
      end
      if (wait_left == 0) begin
        widx = int'(fetch_req.addr[23:2]);
        if (widx < prog_len) begin
          bus_din <= mem[widx];
        end else begin
          $display("fetch from address %h outside the program", fetch_req.addr);
          fetch_errors++;
          bus_din <= fill_word(fetch_req.addr);
        end
        bus_ack   <= 1'b1;
        wait_left = -1;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // timeout and main sequence
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("timeout: the core did not halt within %0d cycles", cycle_limit);
        report_counts();
        $display("Done: errors found");
        $finish;
      end
    end
  end

  initial begin
    rst       = 1'b1;
    end_check = 1'b0;
    load_testdata();
    cycle_limit = prog_len * 45;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (!halted) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);        // nothing may move after the halt
    end_check = 1'b1;
    while (!end_done) begin
      @(negedge clk);
    end
    report_counts();
    if (value_errors + seq_errors + load_errors + fetch_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tb/cpu_testdata.txt ====
# I <program word, next address from 0>   W <expected register> <expected value>
# H on its own line: the core is expected to halt, with no write-back after it
I 41008001  W 1 00008001
I 52008001  W 2 FFFF8001
I 430000FF  W 3 000000FF
I 04260003  W 4 FFFF80FF
I 05240003  W 5 00000001
I 06250003  W 6 FFFF8000
I 07270001  W 7 FFFF0000
I 08280001  W 8 00000002
I 09190002  W 9 00010000
I 4A287FFF  W A 00000000
I 4B210001  W B FFFF0002
I 4C22001F  W C FFFFFFFF
I 4D130001  W D 80004000
I 4E120001  W E 00004000
I 4F11001F  W F 80000000
I 43210000  W 3 FFFF8001
I 04D3000C  W 4 00008001
I 0522000E  W 5 FFFF8001
I 46730000  W 6 FFFF0000
I 47220001  W 7 FFFFC000
I 082A0001  W 8 C0000001
I 092A0002  W 9 3FFF0001
I 4A3A0003  W A FFFE8003
I 0BCA000C  W B 00000001
I 0C1C0002  W C 00000000
I 0E1D0001  W E 00000000
I 4F2E1234  W F 00000000
I 4D1FFFFF  W D 00000000
I 01000008  W 1 C0000001
I 81000000
H

// ==== all.f ====
source/isa_pkg.sv
source/bus_pkg.sv
source/cpu_regfile.sv
source/cpu_mul.sv
source/cpu_alu.sv
source/cpu_ctrl.sv
source/cpu_core.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// ==== Makefile ====
# Verilator build and run of the cpu_core testbench

SIM      ?= verilator
TOP      ?= tb_cpu
VFLAGS   ?= --binary --timing -j 0
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
FILELIST ?= all.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then exit 1; fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
